/* Bender.yml */
package:
  name: board_shell

sources:
  - design/board_pkg.sv
  - design/cfg_spi_rx.sv
  - design/ps2_key_joy.sv
  - design/control_mapper.sv
  - design/scanline_mixer.sv
  - design/sd_dac.sv
  - design/board_shell.sv
  - target: test
    files:
      - tb/board_shell_tb.sv

/* design/board_pkg.sv */
`default_nettype none

package board_pkg;

	// SPI command bytes from the board controller.
	localparam logic [7:0] CMD_STATUS = 8'h1e;
	localparam logic [7:0] CMD_JOY    = 8'h02;

	localparam int unsigned SPI_FRAME_BITS = 40;
	localparam int unsigned SPI_CNT_W      = 6;

	// PS/2 set 2 scan codes.
	localparam logic [7:0] KEY_SPACE = 8'h29;
	localparam logic [7:0] KEY_1     = 8'h16;
	localparam logic [7:0] KEY_2     = 8'h1e;
	localparam logic [7:0] KEY_5     = 8'h2e;
	localparam logic [7:0] KEY_UP    = 8'h75;
	localparam logic [7:0] KEY_DOWN  = 8'h72;
	localparam logic [7:0] KEY_LEFT  = 8'h6b;
	localparam logic [7:0] KEY_RIGHT = 8'h74;
	localparam logic [7:0] KEY_BREAK = 8'hf0;
	localparam logic [7:0] KEY_EXT   = 8'he0;

	localparam int unsigned PS2_CNT_W    = 4;
	localparam int unsigned PS2_STOP_BIT = 10;

	// Colour levels on scanline rows.
	localparam logic [5:0] LVL_FULL  = 6'd63;
	localparam logic [5:0] LVL_DIM25 = 6'd47;
	localparam logic [5:0] LVL_DIM50 = 6'd31;

	typedef struct packed {
		logic [24:0] rsv_hi;
		logic        reset_menu;
		logic        rsv_5;
		logic [1:0]  fx;
		logic        rotate;
		logic        rsv_1;
		logic        reset_req;
	} status_t;

	typedef struct packed {
		logic [2:0] unused;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	typedef struct packed {
		joy_t        joy1;
		joy_t        joy0;
		logic [15:0] pad;
	} joy_pair_t;

	// One payload word, decoded by the command byte.
	typedef union packed {
		status_t   status;
		joy_pair_t joys;
	} spi_payload_u;

	typedef struct packed {
		logic [1:0] rsv;
		logic       right;
		logic       left;
		logic       down;
		logic       up;
		logic       coin;
		logic       start2;
		logic       start1;
		logic       fire;
	} kbjoy_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic start1;
		logic start2;
		logic coin;
		logic core_reset;
	} player_ctl_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} rgb6_t;

endpackage

`default_nettype wire

/* design/board_shell.sv */
`timescale 1ns/1ps
`default_nettype none

module board_shell import board_pkg::*; (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        spi_sck,
	input  logic        spi_di,
	input  logic        spi_ss,
	input  logic        ps2_clk,
	input  logic        ps2_data,
	output logic [5:0]  vga_r,
	output logic [5:0]  vga_g,
	output logic [5:0]  vga_b,
	output logic        vga_hs,
	output logic        vga_vs,
	output logic        audio_l,
	output logic        audio_r,
	output logic        led,
	output player_ctl_t ctl,
	output logic        core_reset,
	input  logic        ce_pix,
	input  logic        core_r,
	input  logic        core_g,
	input  logic        core_b,
	input  logic        core_hs,
	input  logic        core_vs,
	input  logic [15:0] core_audio
);

	status_t status;
	joy_t    joy0;
	joy_t    joy1;
	kbjoy_t  kbjoy;
	rgb6_t   rgb;

	cfg_spi_rx u_cfg (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.spi_sck (spi_sck),
		.spi_di  (spi_di),
		.spi_ss  (spi_ss),
		.status  (status),
		.joy0    (joy0),
		.joy1    (joy1)
	);

	ps2_key_joy u_kbd (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.kbjoy    (kbjoy)
	);

	control_mapper u_ctl (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.status  (status),
		.joy0    (joy0),
		.joy1    (joy1),
		.kbjoy   (kbjoy),
		.ctl     (ctl)
	);

	scanline_mixer u_mixer (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ce_pix  (ce_pix),
		.r       (core_r),
		.g       (core_g),
		.b       (core_b),
		.hs      (core_hs),
		.vs      (core_vs),
		.fx      (status.fx),
		.rgb     (rgb),
		.vga_hs  (vga_hs),
		.vga_vs  (vga_vs)
	);

	// Top 12 bits of the core sample.
	sd_dac u_dac (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.level   (core_audio[15:4]),
		.dac_out (audio_l)
	);

	assign vga_r      = rgb.r;
	assign vga_g      = rgb.g;
	assign vga_b      = rgb.b;
	assign audio_r    = audio_l;
	assign led        = 1'b1;
	assign core_reset = ctl.core_reset;

endmodule

`default_nettype wire

/* design/cfg_spi_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_spi_rx import board_pkg::*; (
	input  logic    clk_sys,
	input  logic    arst_n,
	input  logic    spi_sck,
	input  logic    spi_di,
	input  logic    spi_ss,
	output status_t status,
	output joy_t    joy0,
	output joy_t    joy1
);

	logic [2:0]                sck_q;
	logic [2:0]                ss_q;
	logic [1:0]                di_q;
	logic                      sck_rise;
	logic                      ss_rise;
	logic [SPI_FRAME_BITS-1:0] shift_q;
	logic [SPI_CNT_W-1:0]      bit_cnt;
	logic [7:0]                cmd;
	spi_payload_u              payload;
	logic                      frame_ok;

	// Two sync flops, the third stage only for edge detection.
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sck_q <= '0;
			ss_q  <= '1;
			di_q  <= '0;
		end else begin
			sck_q <= {sck_q[1:0], spi_sck};
			ss_q  <= {ss_q[1:0], spi_ss};
			di_q  <= {di_q[0], spi_di};
		end
	end

	assign sck_rise = sck_q[1] & ~sck_q[2];
	assign ss_rise  = ss_q[1] & ~ss_q[2];

	// MSB first while selected; count saturates on overlong frames.
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			shift_q <= '0;
			bit_cnt <= '0;
		end else if (ss_q[1]) begin
			bit_cnt <= '0;
		end else if (sck_rise) begin
			shift_q <= {shift_q[SPI_FRAME_BITS-2:0], di_q[1]};
			if (bit_cnt != '1) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	assign cmd      = shift_q[SPI_FRAME_BITS-1:SPI_FRAME_BITS-8];
	assign payload  = shift_q[31:0];
	assign frame_ok = ss_rise && (bit_cnt == SPI_CNT_W'(SPI_FRAME_BITS));

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			status <= '0;
			joy0   <= '0;
			joy1   <= '0;
		end else if (frame_ok) begin
			case (cmd)
				CMD_STATUS: status <= payload.status;
				CMD_JOY: begin
					joy0 <= payload.joys.joy0;
					joy1 <= payload.joys.joy1;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/control_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module control_mapper import board_pkg::*; (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  status_t     status,
	input  joy_t        joy0,
	input  joy_t        joy1,
	input  kbjoy_t      kbjoy,
	output player_ctl_t ctl
);

	logic        any_up;
	logic        any_down;
	logic        any_left;
	logic        any_right;
	player_ctl_t ctl_d;

	assign any_up    = kbjoy.up    | joy0.up    | joy1.up;
	assign any_down  = kbjoy.down  | joy0.down  | joy1.down;
	assign any_left  = kbjoy.left  | joy0.left  | joy1.left;
	assign any_right = kbjoy.right | joy0.right | joy1.right;

	always_comb begin
		// Sideways cabinet turns the stick a quarter.
		ctl_d.up         = status.rotate ? any_left  : any_up;
		ctl_d.down       = status.rotate ? any_right : any_down;
		ctl_d.left       = status.rotate ? any_down  : any_left;
		ctl_d.right      = status.rotate ? any_up    : any_right;
		ctl_d.fire       = kbjoy.fire | joy0.fire | joy1.fire;
		ctl_d.start1     = kbjoy.start1;
		ctl_d.start2     = kbjoy.start2;
		ctl_d.coin       = kbjoy.coin;
		ctl_d.core_reset = status.reset_req | status.reset_menu;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ctl <= '{core_reset: 1'b1, default: 1'b0};
		end else begin
			ctl <= ctl_d;
		end
	end

endmodule

`default_nettype wire

/* design/ps2_key_joy.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_key_joy import board_pkg::*; (
	input  logic   clk_sys,
	input  logic   arst_n,
	input  logic   ps2_clk,
	input  logic   ps2_data,
	output kbjoy_t kbjoy
);

	logic [2:0]           clk_q;
	logic [1:0]           data_q;
	logic                 clk_fall;
	logic [PS2_CNT_W-1:0] bit_cnt;
	logic [7:0]           data_sr;
	logic                 par_q;
	logic                 frame_done;
	logic                 brk_q;
	logic                 ext_q;

	// Bus idles high.
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			clk_q  <= '1;
			data_q <= '1;
		end else begin
			clk_q  <= {clk_q[1:0], ps2_clk};
			data_q <= {data_q[0], ps2_data};
		end
	end

	assign clk_fall = clk_q[2] & ~clk_q[1];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt <= '0;
			data_sr <= '0;
			par_q   <= 1'b0;
		end else if (clk_fall) begin
			if (bit_cnt == '0) begin
				// Wait for a start bit.
				if (!data_q[1]) begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (bit_cnt == PS2_CNT_W'(PS2_STOP_BIT)) begin
				bit_cnt <= '0;
			end else begin
				if (bit_cnt == PS2_CNT_W'(PS2_STOP_BIT - 1)) begin
					par_q <= data_q[1];
				end else begin
					data_sr <= {data_q[1], data_sr[7:1]};
				end
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// Stop bit high and odd parity over data plus parity.
	assign frame_done = clk_fall && (bit_cnt == PS2_CNT_W'(PS2_STOP_BIT)) &&
		data_q[1] && (^{par_q, data_sr});

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			kbjoy <= '0;
			brk_q <= 1'b0;
			ext_q <= 1'b0;
		end else if (frame_done) begin
			if (data_sr == KEY_BREAK) begin
				brk_q <= 1'b1;
			end else if (data_sr == KEY_EXT) begin
				ext_q <= 1'b1;
			end else begin
				brk_q <= 1'b0;
				ext_q <= 1'b0;
				if (ext_q) begin
					case (data_sr)
						KEY_UP:    kbjoy.up    <= ~brk_q;
						KEY_DOWN:  kbjoy.down  <= ~brk_q;
						KEY_LEFT:  kbjoy.left  <= ~brk_q;
						KEY_RIGHT: kbjoy.right <= ~brk_q;
						default: ;
					endcase
				end else begin
					case (data_sr)
						KEY_SPACE: kbjoy.fire   <= ~brk_q;
						KEY_1:     kbjoy.start1 <= ~brk_q;
						KEY_2:     kbjoy.start2 <= ~brk_q;
						KEY_5:     kbjoy.coin   <= ~brk_q;
						default: ;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/scanline_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module scanline_mixer import board_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       ce_pix,
	input  logic       r,
	input  logic       g,
	input  logic       b,
	input  logic       hs,
	input  logic       vs,
	input  logic [1:0] fx,
	output rgb6_t      rgb,
	output logic       vga_hs,
	output logic       vga_vs
);

	logic       hs_prev;
	logic       odd_q;
	logic [5:0] hi_lvl;

	// Line parity, restarted in vertical sync.
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hs_prev <= 1'b1;
			odd_q   <= 1'b0;
		end else begin
			hs_prev <= hs;
			if (!vs) begin
				odd_q <= 1'b0;
			end else if (hs_prev && !hs) begin
				odd_q <= ~odd_q;
			end
		end
	end

	always_comb begin
		hi_lvl = LVL_FULL;
		if (odd_q) begin
			case (fx)
				2'd2: hi_lvl = LVL_DIM25;
				2'd3: hi_lvl = LVL_DIM50;
				default: ;
			endcase
		end
	end

	// Colour and sync share one register stage.
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rgb    <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else if (ce_pix) begin
			rgb.r  <= {6{r}} & hi_lvl;
			rgb.g  <= {6{g}} & hi_lvl;
			rgb.b  <= {6{b}} & hi_lvl;
			vga_hs <= hs;
			vga_vs <= vs;
		end
	end

endmodule

`default_nettype wire

/* design/sd_dac.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_dac (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic [11:0] level,
	output logic        dac_out
);

	logic [11:0] acc_q;
	logic [11:0] sum;
	logic        carry;

	assign {carry, sum} = {1'b0, acc_q} + {1'b0, level};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc_q <= '0;
		end else begin
			acc_q <= sum;
		end
	end

	// Overflow density tracks level over each 4096-cycle period.
	assign dac_out = carry;

endmodule

`default_nettype wire

/* project.f */
design/board_pkg.sv
design/cfg_spi_rx.sv
design/ps2_key_joy.sv
design/control_mapper.sv
design/scanline_mixer.sv
design/sd_dac.sv
design/board_shell.sv
tb/board_shell_tb.sv

/* tb/board_shell_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module board_shell_tb import board_pkg::*; ();

	logic        clk_sys;
	logic        arst_n;
	logic        spi_sck;
	logic        spi_di;
	logic        spi_ss;
	logic        ps2_clk;
	logic        ps2_data;
	logic [5:0]  vga_r;
	logic [5:0]  vga_g;
	logic [5:0]  vga_b;
	logic        vga_hs;
	logic        vga_vs;
	logic        audio_l;
	logic        audio_r;
	logic        led;
	player_ctl_t ctl;
	logic        core_reset;
	logic        ce_pix;
	logic        core_r;
	logic        core_g;
	logic        core_b;
	logic        core_hs;
	logic        core_vs;
	logic [15:0] core_audio;

	// Reference state for the control outputs.
	logic       m_rot;
	logic       m_rst;
	logic [7:0] m_j0;
	logic [7:0] m_j1;
	logic [9:0] m_kb;

	int n_tests;
	int n_checks;
	int n_errors;
	int t_checks;
	int t_errors;

	board_shell u_dut (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.spi_sck    (spi_sck),
		.spi_di     (spi_di),
		.spi_ss     (spi_ss),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs),
		.audio_l    (audio_l),
		.audio_r    (audio_r),
		.led        (led),
		.ctl        (ctl),
		.core_reset (core_reset),
		.ce_pix     (ce_pix),
		.core_r     (core_r),
		.core_g     (core_g),
		.core_b     (core_b),
		.core_hs    (core_hs),
		.core_vs    (core_vs),
		.core_audio (core_audio)
	);

	always #20 clk_sys = ~clk_sys;

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		assert (got === exp) else begin
			n_errors++;
			$display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	task automatic begin_test();
		t_checks = n_checks;
		t_errors = n_errors;
	endtask

	task automatic end_test(input string name);
		n_tests++;
		$display("%s: %0d checks, %0d failed", name, n_checks - t_checks, n_errors - t_errors);
	endtask

	function automatic player_ctl_t model_ctl();
		player_ctl_t e;
		logic up;
		logic dn;
		logic lf;
		logic rt;
		up = m_kb[4] | m_j0[3] | m_j1[3];
		dn = m_kb[5] | m_j0[2] | m_j1[2];
		lf = m_kb[6] | m_j0[1] | m_j1[1];
		rt = m_kb[7] | m_j0[0] | m_j1[0];
		e.up = m_rot ? lf : up;
		e.down = m_rot ? rt : dn;
		e.left = m_rot ? dn : lf;
		e.right = m_rot ? up : rt;
		e.fire = m_kb[0] | m_j0[4] | m_j1[4];
		e.start1 = m_kb[1];
		e.start2 = m_kb[2];
		e.coin = m_kb[3];
		e.core_reset = m_rst;
		return e;
	endfunction

	task automatic check_ctl();
		check_val("ctl", ctl, model_ctl());
		check_val("core_reset", core_reset, m_rst);
	endtask

	// Mode 0, MSB first, four clocks per SCK phase.
	// Sends the last nbits bits of the frame.
	task automatic spi_send(input logic [7:0] cmd, input logic [31:0] data, input int nbits);
		logic [39:0] frame;
		frame = {cmd, data};
		@(posedge clk_sys);
		spi_ss  <= 1'b0;
		spi_sck <= 1'b0;
		repeat (3) @(posedge clk_sys);
		for (int i = 0; i < nbits; i++) begin
			spi_di <= frame[nbits - 1 - i];
			repeat (4) @(posedge clk_sys);
			spi_sck <= 1'b1;
			repeat (4) @(posedge clk_sys);
			spi_sck <= 1'b0;
		end
		repeat (3) @(posedge clk_sys);
		spi_ss <= 1'b1;
		// Receiver takes up to 4 cycles and the mapper one more.
		repeat (6) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic send_status(input logic req, input logic menu, input logic rot,
		input logic [1:0] fx);
		spi_send(CMD_STATUS, {25'd0, menu, 1'b0, fx, rot, 1'b0, req}, 40);
		m_rot = rot;
		m_rst = req | menu;
	endtask

	task automatic send_joy(input logic [7:0] j0, input logic [7:0] j1);
		spi_send(CMD_JOY, {j1, j0, 16'h0000}, 40);
		m_j0 = j0;
		m_j1 = j1;
	endtask

	// Start, data LSB first, odd parity, stop.
	task automatic ps2_send(input logic [7:0] code, input logic bad_par);
		logic [10:0] bits;
		bits = {1'b1, (~^code) ^ bad_par, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge clk_sys);
			ps2_data <= bits[i];
			repeat (3) @(posedge clk_sys);
			ps2_clk <= 1'b0;
			repeat (4) @(posedge clk_sys);
			ps2_clk <= 1'b1;
		end
		repeat (6) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic key_event(input logic [7:0] code, input logic ext, input logic brk);
		if (ext)
			ps2_send(KEY_EXT, 1'b0);
		if (brk)
			ps2_send(KEY_BREAK, 1'b0);
		ps2_send(code, 1'b0);
	endtask

	function automatic logic [7:0] key_code(input int idx);
		case (idx)
			0: return KEY_SPACE;
			1: return KEY_1;
			2: return KEY_2;
			3: return KEY_5;
			4: return KEY_UP;
			5: return KEY_DOWN;
			6: return KEY_LEFT;
			default: return KEY_RIGHT;
		endcase
	endfunction

	always @(negedge clk_sys) begin
		if (arst_n)
			check_val("audio_r", audio_r, audio_l);
	end

	// Watchdog sized from frame lengths of the tests.
	initial begin
		int limit;
		limit = 24 * 340 + 40 * 100 + 3 * 4110 + 4 * 200 + 2000;
		repeat (limit) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		int         seed;
		int         ones;
		logic [7:0] j0;
		logic [7:0] j1;
		logic [15:0] lvl;
		logic [5:0] exp_lvl;
		seed = 47793;
		void'($urandom(seed));
		clk_sys = 1'b0;
		arst_n = 1'b0;
		spi_sck = 1'b0;
		spi_di = 1'b0;
		spi_ss = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		ce_pix = 1'b0;
		core_r = 1'b0;
		core_g = 1'b0;
		core_b = 1'b0;
		core_hs = 1'b1;
		core_vs = 1'b1;
		core_audio = '0;
		m_rot = 1'b0;
		m_rst = 1'b0;
		m_j0 = '0;
		m_j1 = '0;
		m_kb = '0;
		n_tests = 0;
		n_checks = 0;
		n_errors = 0;

		begin_test();
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_val("ctl", ctl, 9'h001);
		check_val("core_reset", core_reset, 1'b1);
		check_val("vga_r", vga_r, 6'd0);
		check_val("vga_g", vga_g, 6'd0);
		check_val("vga_b", vga_b, 6'd0);
		check_val("vga_hs", vga_hs, 1'b1);
		check_val("vga_vs", vga_vs, 1'b1);
		check_val("audio_l", audio_l, 1'b0);
		check_val("led", led, 1'b1);
		@(posedge clk_sys);
		arst_n <= 1'b1;
		end_test("reset");

		begin_test();
		send_status(1'b1, 1'b0, 1'b0, 2'd0);
		check_ctl();
		send_status(1'b0, 1'b1, 1'b0, 2'd0);
		check_ctl();
		for (int rot = 0; rot < 2; rot++) begin
			send_status(1'b0, 1'b0, rot[0], 2'd0);
			for (int n = 0; n < 4; n++) begin
				j0 = 8'($urandom);
				j1 = 8'($urandom);
				send_joy(j0, j1);
				check_ctl();
			end
		end
		send_status(1'b0, 1'b0, 1'b0, 2'd0);
		send_joy(8'h00, 8'h00);
		check_ctl();
		// Short frame must leave the joysticks alone.
		spi_send(CMD_JOY, {8'h1f, 8'h1f, 16'h0000}, 39);
		check_ctl();
		end_test("config");

		begin_test();
		for (int k = 0; k < 8; k++) begin
			key_event(key_code(k), k >= 4, 1'b0);
			m_kb[k] = 1'b1;
			check_ctl();
			key_event(key_code(k), k >= 4, 1'b1);
			m_kb[k] = 1'b0;
			check_ctl();
		end
		ps2_send(KEY_SPACE, 1'b1);
		check_ctl();
		end_test("keyboard");

		begin_test();
		@(posedge clk_sys);
		core_r <= 1'b1;
		core_g <= 1'b1;
		core_b <= 1'b1;
		for (int fx = 0; fx < 4; fx++) begin
			send_status(1'b0, 1'b0, 1'b0, fx[1:0]);
			@(posedge clk_sys);
			core_vs <= 1'b0;
			repeat (3) @(posedge clk_sys);
			core_vs <= 1'b1;
			repeat (2) @(posedge clk_sys);
			for (int line = 0; line < 4; line++) begin
				if (line > 0) begin
					@(posedge clk_sys);
					core_hs <= 1'b0;
					repeat (2) @(posedge clk_sys);
					core_hs <= 1'b1;
					repeat (2) @(posedge clk_sys);
				end
				exp_lvl = 6'd63;
				if (line % 2 == 1 && fx == 2)
					exp_lvl = 6'd47;
				if (line % 2 == 1 && fx == 3)
					exp_lvl = 6'd31;
				@(posedge clk_sys);
				ce_pix <= 1'b1;
				@(posedge clk_sys);
				ce_pix <= 1'b0;
				@(negedge clk_sys);
				check_val("vga_r", vga_r, exp_lvl);
				check_val("vga_g", vga_g, exp_lvl);
				check_val("vga_b", vga_b, exp_lvl);
			end
		end
		end_test("scanlines");

		begin_test();
		for (int k = 0; k < 3; k++) begin
			lvl = 16'($urandom);
			@(posedge clk_sys);
			arst_n <= 1'b0;
			core_audio <= lvl;
			repeat (3) @(posedge clk_sys);
			arst_n <= 1'b1;
			ones = 0;
			repeat (4096) begin
				@(negedge clk_sys);
				ones += audio_l;
			end
			check_val("audio_l ones", ones, lvl[15:4]);
		end
		end_test("audio");

		$display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
